//--- source/conv_sum_pkg.sv
// Convolution partial-sum definitions

package conv_sum_pkg;

    // lane and dimension widths
    localparam int DATA_W  = 24;
    localparam int DIM_W   = 12;
    localparam int GROUP_W = 10;

    // 512 bank entries
    localparam int ADDR_W = 9;

    // one lane, unsigned, wraps on overflow
    typedef logic [DATA_W-1:0] lane_t;

    // frame configuration, 46 bits
    typedef struct packed {
        logic [DIM_W-1:0]   img_h;
        logic [DIM_W-1:0]   img_w;
        logic [DIM_W-1:0]   ch_cycles;
        logic [GROUP_W-1:0] out_groups;
    } conv_cfg_t;

    // frame sequence of the controller
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        CONFIG = 2'd1,
        CAL    = 2'd2,
        CYCLE  = 2'd3
    } ctrl_state_t;

endpackage

//--- source/psum_bank.sv
// Partial-sum RAM bank

module psum_bank #(
    parameter int LANES = 4
) (
    input  logic                                    clk,
    input  logic                                    wr_en,
    input  logic [conv_sum_pkg::ADDR_W-1:0]         wr_addr,
    input  conv_sum_pkg::lane_t [LANES-1:0]         wr_data,
    input  logic [conv_sum_pkg::ADDR_W-1:0]         rd_addr,
    output conv_sum_pkg::lane_t [LANES-1:0]         rd_data
);

    localparam int DEPTH = 2 ** conv_sum_pkg::ADDR_W;

    conv_sum_pkg::lane_t [LANES-1:0] mem [0:DEPTH-1];
    conv_sum_pkg::lane_t [LANES-1:0] rd_q;
    conv_sum_pkg::lane_t [LANES-1:0] fwd_q;
    logic                            fwd_hit;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read-first array, old word on a same-cycle collision
    always_ff @(posedge clk) begin
        rd_q <= mem[rd_addr];
    end

    // remember a collision and the word that was written
    always_ff @(posedge clk) begin
        fwd_hit <= wr_en && (wr_addr == rd_addr);
        fwd_q   <= wr_data;
    end

    assign rd_data = fwd_hit ? fwd_q : rd_q;

endmodule

//--- source/psum_sequencer.sv
// Position counters and bank read address

module psum_sequencer (
    input  logic                              clk,
    input  conv_sum_pkg::conv_cfg_t           cfg,
    input  logic                              count_clr,
    input  logic                              inter_valid,
    output logic [conv_sum_pkg::ADDR_W-1:0]   rd_addr,
    output logic                              first_pass,
    output logic                              last_pass
);

    localparam int DIM_W   = conv_sum_pkg::DIM_W;
    localparam int GROUP_W = conv_sum_pkg::GROUP_W;
    localparam int ADDR_W  = conv_sum_pkg::ADDR_W;

    logic [DIM_W-1:0]   col;
    logic [DIM_W-1:0]   pass;
    logic [GROUP_W-1:0] grp;
    logic [DIM_W-1:0]   row;
    logic               col_last;
    logic               grp_last;
    logic               row_last;
    logic [ADDR_W-1:0]  addr_next;

    assign col_last = (col == cfg.img_w - DIM_W'(1));
    assign grp_last = (grp == cfg.out_groups - GROUP_W'(1));
    assign row_last = (row == cfg.img_h - DIM_W'(1));

    assign first_pass = (pass == '0);
    assign last_pass  = (pass == cfg.ch_cycles - DIM_W'(1));

    // column fastest, then pass, group, row
    always_ff @(posedge clk) begin
        if (count_clr) begin
            col  <= '0;
            pass <= '0;
            grp  <= '0;
            row  <= '0;
        end else if (inter_valid) begin
            col <= col_last ? '0 : col + DIM_W'(1);
            if (col_last) begin
                pass <= last_pass ? '0 : pass + DIM_W'(1);
            end
            if (col_last && last_pass) begin
                grp <= grp_last ? '0 : grp + GROUP_W'(1);
            end
            if (col_last && last_pass && grp_last) begin
                row <= row_last ? '0 : row + DIM_W'(1);
            end
        end
    end

    // one bank row per group, img_w entries wide
    assign addr_next = ADDR_W'(col + cfg.img_w * DIM_W'(grp));

    always_ff @(posedge clk) begin
        if (inter_valid) begin
            rd_addr <= addr_next;
        end
    end

    a_bank_fits: assert property (
        @(posedge clk)
        inter_valid |-> (32'(cfg.img_w) * 32'(cfg.out_groups) <= (32'd1 << ADDR_W))
    );

endmodule

//--- source/psum_accumulator.sv
// Lane-parallel partial-sum accumulator

module psum_accumulator #(
    parameter int LANES = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  conv_sum_pkg::lane_t [LANES-1:0]     inter_data,
    input  logic                                inter_valid,
    input  logic [conv_sum_pkg::ADDR_W-1:0]     rd_addr,
    input  logic                                first_pass,
    input  logic                                last_pass,
    input  conv_sum_pkg::lane_t [LANES-1:0]     rd_data,
    output logic                                wr_en,
    output logic [conv_sum_pkg::ADDR_W-1:0]     wr_addr,
    output conv_sum_pkg::lane_t [LANES-1:0]     wr_data,
    output conv_sum_pkg::lane_t [LANES-1:0]     sum_data,
    output logic                                sum_valid
);

    conv_sum_pkg::lane_t [LANES-1:0] data_d1;
    conv_sum_pkg::lane_t [LANES-1:0] data_d2;
    conv_sum_pkg::lane_t [LANES-1:0] operand;
    conv_sum_pkg::lane_t [LANES-1:0] result;
    logic [conv_sum_pkg::ADDR_W-1:0] addr_d;
    logic                            valid_d1;
    logic                            valid_d2;
    logic                            first_d1;
    logic                            first_d2;
    logic                            last_d1;
    logic                            last_d2;
    logic                            chain_hit;

    //////////////////////////////////////////////////////////////////////
    // line up the beat with its bank read
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        data_d1  <= inter_data;
        data_d2  <= data_d1;
        addr_d   <= rd_addr;
        first_d1 <= first_pass;
        first_d2 <= first_d1;
        last_d1  <= last_pass;
        last_d2  <= last_d1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_d1 <= 1'b0;
            valid_d2 <= 1'b0;
        end else begin
            valid_d1 <= inter_valid;
            valid_d2 <= valid_d1;
        end
    end

    // previous beat to the same entry is not in the bank yet
    assign chain_hit = wr_en && (wr_addr == addr_d);
    assign operand   = chain_hit ? wr_data : rd_data;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            result[i] = first_d2 ? data_d2[i] : data_d2[i] + operand[i];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // write back and output
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        wr_data <= result;
        wr_addr <= addr_d;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en     <= 1'b0;
            sum_valid <= 1'b0;
        end else begin
            wr_en     <= valid_d2;
            sum_valid <= valid_d2 && last_d2;
        end
    end

    assign sum_data = wr_data;

    a_no_write_in_reset: assert property (
        @(posedge clk) !rst_n |=> !wr_en
    );

endmodule

//--- source/conv_sum_ctrl.sv
// Frame controller

module conv_sum_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      s_config_valid,
    output logic                      s_config_ready,
    input  logic [31:0]               s_config_data,
    input  logic                      sum_valid,
    output conv_sum_pkg::conv_cfg_t   cfg,
    output logic                      count_clr,
    output logic                      busy,
    output conv_sum_pkg::ctrl_state_t status
);

    localparam int DIM_W  = conv_sum_pkg::DIM_W;
    localparam int LEN_W  = 2 * conv_sum_pkg::DIM_W + conv_sum_pkg::GROUP_W;

    conv_sum_pkg::ctrl_state_t state;
    conv_sum_pkg::ctrl_state_t state_next;
    logic                      cfg_take;
    logic                      word_sel;
    logic                      out_last;
    logic [LEN_W-1:0]          total_len;
    logic [LEN_W-1:0]          out_cnt;

    assign cfg_take = s_config_valid && s_config_ready;
    assign out_last = sum_valid && (out_cnt == total_len - LEN_W'(1));

    //////////////////////////////////////////////////////////////////////
    // state sequence
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            conv_sum_pkg::IDLE:   state_next = conv_sum_pkg::CONFIG;
            conv_sum_pkg::CONFIG: if (cfg_take && word_sel) state_next = conv_sum_pkg::CAL;
            conv_sum_pkg::CAL:    state_next = conv_sum_pkg::CYCLE;
            conv_sum_pkg::CYCLE:  if (out_last) state_next = conv_sum_pkg::IDLE;
            default:              state_next = conv_sum_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= conv_sum_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ready opens after IDLE, closes on the second word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_config_ready <= 1'b0;
            word_sel       <= 1'b0;
        end else if (state == conv_sum_pkg::IDLE) begin
            s_config_ready <= 1'b1;
            word_sel       <= 1'b0;
        end else if (cfg_take) begin
            word_sel <= 1'b1;
            if (word_sel) begin
                s_config_ready <= 1'b0;
            end
        end
    end

    // word 0 is the image size, word 1 the channel setup
    always_ff @(posedge clk) begin
        if (cfg_take) begin
            if (!word_sel) begin
                cfg.img_w <= s_config_data[DIM_W-1:0];
                cfg.img_h <= s_config_data[2*DIM_W-1:DIM_W];
            end else begin
                cfg.ch_cycles  <= s_config_data[DIM_W-1:0];
                cfg.out_groups <= s_config_data[DIM_W+conv_sum_pkg::GROUP_W-1:DIM_W];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output beat count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == conv_sum_pkg::CAL) begin
            total_len <= LEN_W'(cfg.img_h) * LEN_W'(cfg.img_w) * LEN_W'(cfg.out_groups);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || count_clr) begin
            out_cnt <= '0;
        end else if (sum_valid) begin
            out_cnt <= out_cnt + LEN_W'(1);
        end
    end

    assign count_clr = (state == conv_sum_pkg::CAL);
    assign busy      = (state != conv_sum_pkg::CYCLE);
    assign status    = state;

    a_cfg_only_in_config: assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_take |-> (state == conv_sum_pkg::CONFIG)
    );

endmodule

//--- source/conv_sum_top.sv
// Convolution partial-sum unit

module conv_sum_top #(
    parameter int LANES = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              s_config_valid,
    output logic                              s_config_ready,
    input  logic [31:0]                       s_config_data,
    input  conv_sum_pkg::lane_t [LANES-1:0]   inter_data,
    input  logic                              inter_valid,
    output logic                              busy,
    output conv_sum_pkg::lane_t [LANES-1:0]   sum_data,
    output logic                              sum_valid,
    output conv_sum_pkg::ctrl_state_t         status
);

    conv_sum_pkg::conv_cfg_t         cfg;
    logic                            count_clr;
    logic [conv_sum_pkg::ADDR_W-1:0] rd_addr;
    logic [conv_sum_pkg::ADDR_W-1:0] wr_addr;
    logic                            first_pass;
    logic                            last_pass;
    logic                            wr_en;
    conv_sum_pkg::lane_t [LANES-1:0] wr_data;
    conv_sum_pkg::lane_t [LANES-1:0] rd_data;

    conv_sum_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .s_config_valid (s_config_valid),
        .s_config_ready (s_config_ready),
        .s_config_data  (s_config_data),
        .sum_valid      (sum_valid),
        .cfg            (cfg),
        .count_clr      (count_clr),
        .busy           (busy),
        .status         (status)
    );

    psum_sequencer u_seq (
        .clk         (clk),
        .cfg         (cfg),
        .count_clr   (count_clr),
        .inter_valid (inter_valid),
        .rd_addr     (rd_addr),
        .first_pass  (first_pass),
        .last_pass   (last_pass)
    );

    psum_bank #(.LANES(LANES)) u_bank (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    psum_accumulator #(.LANES(LANES)) u_acc (
        .clk         (clk),
        .rst_n       (rst_n),
        .inter_data  (inter_data),
        .inter_valid (inter_valid),
        .rd_addr     (rd_addr),
        .first_pass  (first_pass),
        .last_pass   (last_pass),
        .rd_data     (rd_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .sum_data    (sum_data),
        .sum_valid   (sum_valid)
    );

endmodule

//--- dv/tb_clock_gen.sv
// Testbench clock and reset

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- dv/conv_sum_tb.sv
// Partial-sum unit testbench

module conv_sum_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LANES    = 4;
    localparam int REC_W    = LANES + 1;
    localparam int MEM_SIZE = 1024;

    localparam logic [3:0] KIND_TEST = 4'h1;
    localparam logic [3:0] KIND_CFG  = 4'h2;
    localparam logic [3:0] KIND_BEAT = 4'h3;
    localparam logic [3:0] KIND_EXP  = 4'h4;
    localparam logic [3:0] KIND_END  = 4'hf;

    typedef conv_sum_pkg::lane_t [LANES-1:0] vec_t;

    // one line of the golden file
    typedef struct packed {
        logic [3:0]  kind;
        logic [31:0] arg;
        vec_t        lanes;
    } record_t;

    logic                      clk;
    logic                      rst_n;
    logic                      s_config_valid;
    logic                      s_config_ready;
    logic [31:0]               s_config_data;
    vec_t                      inter_data;
    logic                      inter_valid;
    logic                      busy;
    vec_t                      sum_data;
    logic                      sum_valid;
    conv_sum_pkg::ctrl_state_t status;

    logic [31:0] golden [0:MEM_SIZE-1];
    vec_t        expect_q [$];
    string       test_name;
    string       waiting_on;
    int          test_errors      = 0;
    int          test_sums        = 0;
    int          test_count       = 0;
    int          total_errors     = 0;
    int          total_checks     = 0;
    int          outputs_expected = 0;
    int          cycle_count      = 0;
    int          cycle_limit      = 0;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(5)) clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    conv_sum_top #(.LANES(LANES)) dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .s_config_valid (s_config_valid),
        .s_config_ready (s_config_ready),
        .s_config_data  (s_config_data),
        .inter_data     (inter_data),
        .inter_valid    (inter_valid),
        .busy           (busy),
        .sum_data       (sum_data),
        .sum_valid      (sum_valid),
        .status         (status)
    );

    //////////////////////////////////////////////////////////////////////
    // golden file access
    //////////////////////////////////////////////////////////////////////

    function automatic record_t fetch_record(int idx);
        record_t rec;
        rec.kind = golden[idx * REC_W][3:0];
        rec.arg  = golden[idx * REC_W + 1];
        for (int i = 0; i < LANES; i++) begin
            rec.lanes[i] = golden[idx * REC_W + 1 + i][conv_sum_pkg::DATA_W-1:0];
        end
        return rec;
    endfunction

    function automatic int count_beats();
        int beats;
        int idx;
        beats = 0;
        idx   = 0;
        while (idx < MEM_SIZE / REC_W && golden[idx * REC_W][3:0] != KIND_END) begin
            if (golden[idx * REC_W][3:0] == KIND_BEAT) begin
                beats++;
            end
            idx++;
        end
        return beats;
    endfunction

    function automatic string name_of(logic [31:0] id);
        string s;
        case (id)
            32'd1:   s = "single_pass";
            32'd2:   s = "accumulate_3pass";
            32'd3:   s = "two_groups";
            32'd4:   s = "back_to_back";
            default: s = "unnamed";
        endcase
        return s;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus and bookkeeping
    //////////////////////////////////////////////////////////////////////

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic start_test(logic [31:0] id);
        test_name   = name_of(id);
        test_errors = 0;
        test_sums   = 0;
        test_count++;
    endtask

    // holds valid until the word is taken
    task automatic push_word(logic [31:0] word);
        waiting_on     = "configuration ready";
        s_config_valid = 1'b1;
        s_config_data  = word;
        while (!s_config_ready) @(negedge clk);
        @(negedge clk);
        s_config_valid = 1'b0;
    endtask

    task automatic apply_config(logic [31:0] w0, logic [31:0] w1);
        outputs_expected = int'(w0[23:12]) * int'(w0[11:0]) * int'(w1[21:12]);
        push_word(w0);
        push_word(w1);
        total_checks++;
        if (s_config_ready) begin
            $display("ERROR %s: config ready still high after two words", test_name);
            note_error();
        end
        waiting_on = "busy to fall";
        while (busy) @(negedge clk);
        total_checks++;
        if (status !== conv_sum_pkg::CYCLE) begin
            $display("FAILED %s: status expected %0d actual %0d",
                     test_name, conv_sum_pkg::CYCLE, status);
            note_error();
        end
    endtask

    task automatic drive_beat(vec_t lanes);
        inter_valid = 1'b1;
        inter_data  = lanes;
        @(negedge clk);
    endtask

    task automatic finish_test();
        waiting_on = "end of frame";
        while (!busy) @(negedge clk);
        total_checks++;
        if (test_sums != outputs_expected) begin
            $display("FAILED %s: sum count expected %0d actual %0d",
                     test_name, outputs_expected, test_sums);
            note_error();
        end
        total_checks++;
        if (expect_q.size() != 0) begin
            $display("ERROR %s: %0d expected sums never arrived", test_name, expect_q.size());
            note_error();
            expect_q.delete();
        end
        if (test_errors == 0) begin
            $display("test %s: passed, %0d sums", test_name, test_sums);
        end else begin
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        record_t     rec;
        logic [31:0] cfg_word0;
        bit          cfg_half;
        bit          done;
        int          idx;

        s_config_valid = 1'b0;
        s_config_data  = '0;
        inter_valid    = 1'b0;
        inter_data     = '0;
        test_name      = "reset";
        waiting_on     = "reset release";
        cfg_word0      = '0;
        cfg_half       = 1'b0;
        done           = 1'b0;
        idx            = 0;

        $readmemh("dv/conv_sum_golden.txt", golden);
        cycle_limit = count_beats() + 200;

        @(posedge rst_n);
        total_checks++;
        if (!busy || s_config_ready || sum_valid) begin
            $display("FAILED %s: busy ready valid expected 100 actual %b%b%b",
                     test_name, busy, s_config_ready, sum_valid);
            note_error();
        end
        total_checks++;
        if (status !== conv_sum_pkg::IDLE) begin
            $display("FAILED %s: status expected %0d actual %0d",
                     test_name, conv_sum_pkg::IDLE, status);
            note_error();
        end

        while (!done) begin
            if (idx >= MEM_SIZE / REC_W) begin
                $display("ERROR golden file ends without an end record");
                note_error();
                done = 1'b1;
            end else begin
                rec = fetch_record(idx);
                idx++;
                if (rec.kind != KIND_BEAT) begin
                    inter_valid = 1'b0;
                end
                case (rec.kind)
                    KIND_TEST: begin
                        if (test_count > 0) begin
                            finish_test();
                        end
                        start_test(rec.arg);
                    end
                    KIND_CFG: begin
                        if (!cfg_half) begin
                            cfg_word0 = rec.arg;
                            cfg_half  = 1'b1;
                        end else begin
                            apply_config(cfg_word0, rec.arg);
                            cfg_half = 1'b0;
                        end
                    end
                    KIND_BEAT: drive_beat(rec.lanes);
                    KIND_EXP:  expect_q.push_back(rec.lanes);
                    KIND_END: begin
                        if (test_count > 0) begin
                            finish_test();
                        end
                        done = 1'b1;
                    end
                    default: begin
                        $display("ERROR golden record %0d has an unknown kind", idx - 1);
                        note_error();
                        done = 1'b1;
                    end
                endcase
            end
        end

        $display("tests %0d, checks %0d, errors %0d", test_count, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // outputs are stable on the falling edge
    always @(negedge clk) begin
        vec_t exp_vec;
        if (rst_n && sum_valid) begin
            test_sums++;
            total_checks++;
            if (expect_q.size() == 0) begin
                $display("ERROR %s: a sum arrived with no expected value left", test_name);
                note_error();
            end else begin
                exp_vec = expect_q.pop_front();
                if (sum_data !== exp_vec) begin
                    $display("FAILED %s: sum %0d expected %h actual %h",
                             test_name, test_sums, exp_vec, sum_data);
                    note_error();
                end
            end
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("ERROR timeout after %0d cycles waiting for %s", cycle_count, waiting_on);
            $display("Done: errors found");
            $finish;
        end
    end

endmodule

//--- dv/conv_sum_golden.txt
// columns: kind, then lane 0 to lane 3 (kinds 1 and 2 use the first column only)
// kind 1 test id, 2 config word, 3 input beat, 4 expected sum, f end; sums precede beats

// single pass, 1x2 image
1 00000001 000000 000000 000000
2 00001002 000000 000000 000000
2 00001001 000000 000000 000000
4 123456 abcdef 000001 ffffff
4 800000 00ff00 555555 aaaaaa
3 123456 abcdef 000001 ffffff
3 800000 00ff00 555555 aaaaaa
// three passes over two columns, with lane wrap
1 00000002 000000 000000 000000
2 00001002 000000 000000 000000
2 00001003 000000 000000 000000
4 000060 000015 000001 000006
4 011100 022200 033300 044400
3 000010 fffff0 800000 000001
3 000100 000200 000300 000400
3 000020 000020 800000 000002
3 001000 002000 003000 004000
3 000030 000005 000001 000003
3 010000 020000 030000 040000
// two rows, two groups, two passes
1 00000003 000000 000000 000000
2 00002001 000000 000000 000000
2 00002002 000000 000000 000000
4 000011 000022 000033 000044
4 001100 002200 003300 004400
4 0a0005 0b0006 0c0007 0d0008
4 000000 000000 000001 000003
3 000001 000002 000003 000004
3 000010 000020 000030 000040
3 000100 000200 000300 000400
3 001000 002000 003000 004000
3 0a0000 0b0000 0c0000 0d0000
3 000005 000006 000007 000008
3 ffffff 000001 7fffff 100000
3 000001 ffffff 800002 f00003
// one column, three passes every cycle
1 00000004 000000 000000 000000
2 00001001 000000 000000 000000
2 00001003 000000 000000 000000
4 000018 600000 999999 000001
3 000007 100000 333333 fffffe
3 000008 200000 333333 000001
3 000009 300000 333333 000002
f 00000000 000000 000000 000000

//--- list.f
source/conv_sum_pkg.sv
source/psum_bank.sv
source/psum_sequencer.sv
source/psum_accumulator.sv
source/conv_sum_ctrl.sv
source/conv_sum_top.sv
dv/tb_clock_gen.sv
dv/conv_sum_tb.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the partial-sum testbench
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module conv_sum_tb -f list.f -o conv_sum_sim \
    && ./obj_dir/conv_sum_sim | tee sim.log
grep -q "Done: no errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
